//--- design/llq_cfg.svh
// Build-time sizes of the queue controller, included wherever a size or width is needed
`ifndef LLQ_CFG_SVH
`define LLQ_CFG_SVH

// Width of a pushed data word
`define LLQ_DATA_W 32

// Number of logical FIFO contexts
`define LLQ_CTXT 8

// Link slots in the shared pool, small so the pool can be filled in simulation
`define LLQ_LINKS 16

`endif

//--- design/llq_pkg.sv
// Shared widths and types of the linked-list queue controller, referenced by scoped name
`include "llq_cfg.svh"

package llq_pkg;

  localparam int DATA_W = `LLQ_DATA_W;
  localparam int CTXT_W = $clog2(`LLQ_CTXT);  // Context index bits
  localparam int ADDR_W = $clog2(`LLQ_LINKS); // Slot index bits

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [CTXT_W-1:0] ctxt_t;
  typedef logic [ADDR_W-1:0] addr_t;

  // One bit per context
  typedef logic [`LLQ_CTXT-1:0] ctxt_mask_t;

  // One bit per link slot
  typedef logic [`LLQ_LINKS-1:0] slot_mask_t;

  // Per-context queue state
  // Head is the newest entry, tail the oldest
  typedef struct packed {
    logic  empty;
    addr_t head;
    addr_t tail;
  } ctxt_state_t;

endpackage

//--- design/llq_op_if.sv
// Accepted stage-0 command passed from the command stage to the queue engine, with stall back
interface llq_op_if;

  logic           s0_valid; // Stage 0 holds an op
  logic           s0_push;  // Push, else pop
  llq_pkg::ctxt_t s0_ctxt;
  llq_pkg::data_t s0_data;
  llq_pkg::addr_t s0_link;  // Slot allocated to a push
  logic           stall;    // Stage 0 must hold its op

  // Command stage side
  modport issue (
    output s0_valid,
    output s0_push,
    output s0_ctxt,
    output s0_data,
    output s0_link,
    input  stall
  );

  // Engine side
  modport engine (
    input  s0_valid,
    input  s0_push,
    input  s0_ctxt,
    input  s0_data,
    input  s0_link,
    output stall
  );

endinterface

//--- design/llq_result_if.sv
// Finished operation handed from the queue engine to the lookup and status output stage
interface llq_result_if;

  logic           res_valid; // One-cycle strobe per finished op
  logic           res_rnw;   // Pop, else push
  llq_pkg::data_t res_data;
  llq_pkg::addr_t res_addr;  // Pushed or popped slot
  logic           res_fault; // Pop to an empty context
  llq_pkg::ctxt_t res_ctxt;
  logic           res_empty; // Context empty after this op

  // Engine side
  modport engine (
    output res_valid,
    output res_rnw,
    output res_data,
    output res_addr,
    output res_fault,
    output res_ctxt,
    output res_empty
  );

  // Output stage side
  modport sink (
    input res_valid,
    input res_rnw,
    input res_data,
    input res_addr,
    input res_fault,
    input res_ctxt,
    input res_empty
  );

endinterface

//--- design/llq_cmd_stage.sv
// Stage-0 command register with accept and stall handling, fed by the top-level command port
module llq_cmd_stage (
  input  logic           clk,
  input  logic           rst,
  input  logic           cmd_pass,
  input  logic           cmd_push,
  input  llq_pkg::data_t cmd_data,
  input  llq_pkg::ctxt_t cmd_ctxt,
  input  logic           full,      // Pool has no free slot
  input  llq_pkg::addr_t alloc_id,  // Lowest free slot
  output logic           cmd_accept,
  output logic           alloc,
  llq_op_if.issue        op
);

  logic           rdy_q;   // Low through reset
  logic           take;    // Command taken this cycle
  logic           valid_q;
  logic           push_q;
  llq_pkg::ctxt_t ctxt_q;
  llq_pkg::data_t data_q;
  llq_pkg::addr_t link_q;

  // A pop is never refused for fullness
  assign cmd_accept = rdy_q & ~op.stall & ~(cmd_push & full);
  assign take       = cmd_pass & cmd_accept;
  assign alloc      = take & cmd_push;  // Claims alloc_id in the pool

  always_ff @(posedge clk) begin
    if (rst) begin
      rdy_q   <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      rdy_q   <= 1'b1;
      valid_q <= take | (valid_q & op.stall); // Held op stays valid
    end
  end

  // Payload, no reset
  always_ff @(posedge clk) begin
    if (take) begin
      push_q <= cmd_push;
      ctxt_q <= cmd_ctxt;
      data_q <= cmd_data;
      link_q <= alloc_id;  // Only meaningful for a push
    end
  end

  assign op.s0_valid = valid_q;
  assign op.s0_push  = push_q;
  assign op.s0_ctxt  = ctxt_q;
  assign op.s0_data  = data_q;
  assign op.s0_link  = link_q;

endmodule

//--- design/llq_free_pool.sv
// Free-slot bitset of the shared link pool, allocating the lowest free slot and flagging full
module llq_free_pool (
  input  logic           clk,
  input  logic           rst,
  input  logic           alloc,       // Claim alloc_id
  input  logic           release_en,  // Return release_id
  input  llq_pkg::addr_t release_id,
  output llq_pkg::addr_t alloc_id,
  output logic           full
);

  localparam int NLINKS = $bits(llq_pkg::slot_mask_t);

  llq_pkg::slot_mask_t used_q;  // Set bit marks a live slot

  // Find first free, scanning down so the lowest clear bit wins
  always_comb begin
    alloc_id = '0;
    for (int i = NLINKS - 1; i >= 0; i--) begin
      if (!used_q[i]) begin
        alloc_id = llq_pkg::addr_t'(i);
      end
    end
  end

  assign full = &used_q;  // No clear bit left

  // Alloc and release never name the same slot in one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      used_q <= '0;
    end else begin
      if (alloc) begin
        used_q[alloc_id] <= 1'b1;
      end
      if (release_en) begin
        used_q[release_id] <= 1'b0;
      end
    end
  end

endmodule

//--- design/llq_link_ram.sv
// Single-port link RAM holding each slot's next-slot pointer, used by the queue engine
module llq_link_ram (
  input  logic           clk,
  input  logic           en,
  input  logic           wen,   // Write when enabled, else read
  input  llq_pkg::addr_t addr,
  input  llq_pkg::addr_t din,
  output llq_pkg::addr_t dout   // Valid the cycle after a read
);

  localparam int DEPTH = $bits(llq_pkg::slot_mask_t);

  llq_pkg::addr_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (en) begin
      if (wen) begin
        mem[addr] <= din;
      end else begin
        dout <= mem[addr];
      end
    end
  end

endmodule

//--- design/llq_queue_engine.sv
// Per-context head and tail registers, hazard stall and stage-1 update of the queue controller
module llq_queue_engine (
  input  logic           clk,
  input  logic           rst,
  llq_op_if.engine       op,
  llq_result_if.engine   res,
  output logic           release_en,
  output llq_pkg::addr_t release_id
);

  localparam int NCTXT = $bits(llq_pkg::ctxt_mask_t);

  llq_pkg::ctxt_state_t state_q [NCTXT]; // One per context
  llq_pkg::ctxt_state_t s0_state;
  llq_pkg::ctxt_state_t s1_state;
  llq_pkg::ctxt_state_t s1_next;         // State written as the op leaves stage 1
  logic                 adv;             // Stage 0 moves to stage 1
  logic                 s1_valid_q;
  logic                 s1_push_q;
  logic                 s1_fault_q;
  llq_pkg::ctxt_t       s1_ctxt_q;
  llq_pkg::data_t       s1_data_q;
  llq_pkg::addr_t       s1_slot_q;       // Pushed or popped slot
  logic                 link_en;
  llq_pkg::addr_t       link_addr;
  llq_pkg::addr_t       link_dout;

  // Stage 1 still owes this context its update, so stage 0 must wait
  assign op.stall = op.s0_valid & s1_valid_q & (s1_ctxt_q == op.s0_ctxt);
  assign adv      = op.s0_valid & ~op.stall;
  assign s0_state = state_q[op.s0_ctxt];

  // Push links new slot behind head, pop reads the entry after tail
  assign link_en   = adv & ~s0_state.empty;
  assign link_addr = op.s0_push ? s0_state.head : s0_state.tail;

  llq_link_ram u_link_ram (
    .clk  (clk),
    .en   (link_en),
    .wen  (op.s0_push),
    .addr (link_addr),
    .din  (op.s0_link),
    .dout (link_dout)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= adv;  // Bubble behind a stall
    end
  end

  always_ff @(posedge clk) begin
    if (adv) begin
      s1_push_q  <= op.s0_push;
      s1_ctxt_q  <= op.s0_ctxt;
      s1_data_q  <= op.s0_data;
      s1_slot_q  <= op.s0_push ? op.s0_link : s0_state.tail; // Old tail is the popped slot
      s1_fault_q <= ~op.s0_push & s0_state.empty;
    end
  end

  // Unchanged since stage 0, the stall keeps same-context ops apart
  assign s1_state = state_q[s1_ctxt_q];

  always_comb begin
    s1_next = s1_state;
    if (s1_push_q) begin
      s1_next.empty = 1'b0;
      s1_next.head  = s1_slot_q;  // Newest entry
      if (s1_state.empty) begin
        s1_next.tail = s1_slot_q; // Also the oldest
      end
    end else if (!s1_fault_q) begin
      if (s1_state.head == s1_state.tail) begin
        s1_next.empty = 1'b1;     // Last entry popped
      end else begin
        s1_next.tail = link_dout; // Next oldest from the link RAM
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NCTXT; i++) begin
        state_q[i] <= '{empty: 1'b1, head: '0, tail: '0};
      end
    end else if (s1_valid_q) begin
      state_q[s1_ctxt_q] <= s1_next;
    end
  end

  // Popped slot goes back to the pool as it leaves stage 1
  assign release_en = s1_valid_q & ~s1_push_q & ~s1_fault_q;
  assign release_id = s1_slot_q;

  assign res.res_valid = s1_valid_q;
  assign res.res_rnw   = ~s1_push_q;
  assign res.res_data  = s1_data_q;
  assign res.res_addr  = s1_slot_q;
  assign res.res_fault = s1_fault_q;
  assign res.res_ctxt  = s1_ctxt_q;
  assign res.res_empty = s1_next.empty;

endmodule

//--- design/llq_lookup_out.sv
// Registered lookup port and per-context empty vector, driven from the queue engine's results
module llq_lookup_out (
  input  logic                clk,
  input  logic                rst,
  llq_result_if.sink          res,
  output logic                lkup_pass_r,
  output logic                lkup_rnw_r,
  output llq_pkg::data_t      lkup_data_r,
  output llq_pkg::addr_t      lkup_addr_r,
  output logic                lkup_empty_fault_r,
  output llq_pkg::ctxt_mask_t empty_r
);

  // Strobe and status
  always_ff @(posedge clk) begin
    if (rst) begin
      lkup_pass_r <= 1'b0;
      empty_r     <= '1;  // Every context starts empty
    end else begin
      lkup_pass_r <= res.res_valid;
      if (res.res_valid) begin
        empty_r[res.res_ctxt] <= res.res_empty;
      end
    end
  end

  // Lookup fields, held between strobes
  always_ff @(posedge clk) begin
    if (res.res_valid) begin
      lkup_rnw_r         <= res.res_rnw;
      lkup_data_r        <= res.res_data;
      lkup_addr_r        <= res.res_addr;  // Data RAM address
      lkup_empty_fault_r <= res.res_fault;
    end
  end

endmodule

//--- design/llq_top.sv
// Top level of the linked-list queue controller, wiring the command, pool, engine and output blocks
module llq_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                cmd_pass,
  input  logic                cmd_push,
  input  llq_pkg::data_t      cmd_data,
  input  llq_pkg::ctxt_t      cmd_ctxt,
  output logic                cmd_accept,
  output logic                lkup_pass_r,
  output logic                lkup_rnw_r,
  output llq_pkg::data_t      lkup_data_r,
  output llq_pkg::addr_t      lkup_addr_r,
  output logic                lkup_empty_fault_r,
  output logic                full_r,
  output llq_pkg::ctxt_mask_t empty_r
);

  logic           alloc;       // Push taken, claims alloc_id
  llq_pkg::addr_t alloc_id;
  logic           full;
  logic           release_en;  // Pop retired
  llq_pkg::addr_t release_id;

  llq_op_if     op_bus ();
  llq_result_if res_bus ();

  llq_cmd_stage u_cmd_stage (
    .clk        (clk),
    .rst        (rst),
    .cmd_pass   (cmd_pass),
    .cmd_push   (cmd_push),
    .cmd_data   (cmd_data),
    .cmd_ctxt   (cmd_ctxt),
    .full       (full),
    .alloc_id   (alloc_id),
    .cmd_accept (cmd_accept),
    .alloc      (alloc),
    .op         (op_bus.issue)
  );

  llq_free_pool u_free_pool (
    .clk        (clk),
    .rst        (rst),
    .alloc      (alloc),
    .release_en (release_en),
    .release_id (release_id),
    .alloc_id   (alloc_id),
    .full       (full)
  );

  llq_queue_engine u_queue_engine (
    .clk        (clk),
    .rst        (rst),
    .op         (op_bus.engine),
    .res        (res_bus.engine),
    .release_en (release_en),
    .release_id (release_id)
  );

  llq_lookup_out u_lookup_out (
    .clk                (clk),
    .rst                (rst),
    .res                (res_bus.sink),
    .lkup_pass_r        (lkup_pass_r),
    .lkup_rnw_r         (lkup_rnw_r),
    .lkup_data_r        (lkup_data_r),
    .lkup_addr_r        (lkup_addr_r),
    .lkup_empty_fault_r (lkup_empty_fault_r),
    .empty_r            (empty_r)
  );

  // Pool full as a registered status
  always_ff @(posedge clk) begin
    if (rst) begin
      full_r <= 1'b0;
    end else begin
      full_r <= full;
    end
  end

endmodule

//--- bench/llq_tb.sv
// Testbench for llq_top driving random and directed push and pop traffic against a queue model
`include "llq_cfg.svh"

module llq_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NCTXT  = `LLQ_CTXT;
  localparam int NLINKS = `LLQ_LINKS;
  localparam int TMO    = 200;  // Cycles allowed per wait

  typedef struct packed {
    logic           push;
    llq_pkg::ctxt_t ctxt;
    llq_pkg::data_t data;
  } cmd_t;

  typedef struct packed {
    logic           rnw;
    logic           fault;
    llq_pkg::addr_t addr;   // Oldest slot of a pop
    llq_pkg::data_t data;
  } exp_t;

  logic clk = 1'b0;
  logic rst;
  logic cmd_pass;
  logic cmd_push;
  llq_pkg::data_t cmd_data;
  llq_pkg::ctxt_t cmd_ctxt;
  logic cmd_accept;
  logic lkup_pass_r;
  logic lkup_rnw_r;
  llq_pkg::data_t lkup_data_r;
  llq_pkg::addr_t lkup_addr_r;
  logic lkup_empty_fault_r;
  logic full_r;
  llq_pkg::ctxt_mask_t empty_r;

  cmd_t           pending [$];           // Accepted but lookup not yet seen
  llq_pkg::addr_t slots [NCTXT][$];      // Per-context slots with the oldest first
  bit             live [NLINKS];
  int             drv_cnt [NCTXT];       // Entries as the driver counts them
  int             drv_used;

  llq_top u_llq_top (.*);

  always #20 clk = ~clk;

  task automatic report_timeout(input string what);
    $display("Timeout after %0d cycles: %s", TMO, what);
    $display("Simulation failed");
    $fatal(1, "Run stopped on timeout");
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Error %s: expected %b, actual %b", name, exp, act);
      $display("Simulation failed");
      $fatal(1, "Run stopped on mismatch");
    end
  endtask

  task automatic check_addr(input string name, input llq_pkg::addr_t exp,
                            input llq_pkg::addr_t act);
    if (act !== exp) begin
      $display("Error %s: expected %0d, actual %0d", name, exp, act);
      $display("Simulation failed");
      $fatal(1, "Run stopped on mismatch");
    end
  endtask

  task automatic check_data(input string name, input llq_pkg::data_t exp,
                            input llq_pkg::data_t act);
    if (act !== exp) begin
      $display("Error %s: expected %h, actual %h", name, exp, act);
      $display("Simulation failed");
      $fatal(1, "Run stopped on mismatch");
    end
  endtask

  task automatic check_empty(input string name, input llq_pkg::ctxt_mask_t exp,
                             input llq_pkg::ctxt_mask_t act);
    if (act !== exp) begin
      $display("Error %s: expected %b, actual %b", name, exp, act);
      $display("Simulation failed");
      $fatal(1, "Run stopped on mismatch");
    end
  endtask

  // Reference model of the expected lookup for the oldest accepted command
  function automatic exp_t predict_lookup(input cmd_t c);
    exp_t e;
    e.rnw   = ~c.push;
    e.fault = ~c.push && (slots[c.ctxt].size() == 0); // Pop of an empty context
    e.addr  = '0;
    if (!c.push && !e.fault) begin
      e.addr = slots[c.ctxt][0];
    end
    e.data = c.data;
    return e;
  endfunction

  function automatic llq_pkg::ctxt_mask_t model_empty();
    llq_pkg::ctxt_mask_t m;
    for (int i = 0; i < NCTXT; i++) begin
      m[i] = (slots[i].size() == 0);
    end
    return m;
  endfunction

  // Lookup outputs are stable at the falling edge
  always @(negedge clk) begin
    cmd_t c;
    exp_t e;
    if (!rst && lkup_pass_r) begin
      if (pending.size() == 0) begin
        $display("Lookup strobe seen with no command outstanding");
        $display("Simulation failed");
        $fatal(1, "Run stopped on unexpected lookup");
      end
      c = pending.pop_front();
      e = predict_lookup(c);
      check_bit("lookup rnw", e.rnw, lkup_rnw_r);
      check_bit("lookup empty fault", e.fault, lkup_empty_fault_r);
      if (c.push) begin
        check_data("push data", e.data, lkup_data_r);
        check_bit("push slot already live", 1'b0, live[lkup_addr_r]);
        live[lkup_addr_r] = 1'b1;
        slots[c.ctxt].push_back(lkup_addr_r);
      end else if (!e.fault) begin
        check_addr("pop slot", e.addr, lkup_addr_r);
        live[e.addr] = 1'b0;
        void'(slots[c.ctxt].pop_front());
      end
      check_empty("empty vector", model_empty(), empty_r); // Fault leaves model as is
    end
  end

  // Called at a falling edge and returns at the falling edge after the take
  task automatic issue_cmd(input logic push, input llq_pkg::ctxt_t ctxt,
                           input llq_pkg::data_t data);
    cmd_t c;
    int   n;
    bit   taken;
    c.push   = push;
    c.ctxt   = ctxt;
    c.data   = data;
    cmd_pass = 1'b1;
    cmd_push = push;
    cmd_ctxt = ctxt;
    cmd_data = data;
    taken = 1'b0;
    n = 0;
    while (!taken && n < TMO) begin
      #1;                     // Accept settled well before the rising edge
      if (cmd_accept) begin
        taken = 1'b1;
        pending.push_back(c);
      end
      @(negedge clk);
      n++;
    end
    cmd_pass = 1'b0;
    if (!taken) begin
      report_timeout("command was never accepted");
    end
    if (push) begin
      drv_cnt[ctxt]++;
      drv_used++;
    end else if (drv_cnt[ctxt] > 0) begin
      drv_cnt[ctxt]--;
      drv_used--;
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (pending.size() != 0 && n < TMO) begin
      @(negedge clk);
      n++;
    end
    if (pending.size() != 0) begin
      report_timeout("lookup for an accepted command never came");
    end
  endtask

  task automatic wait_full(input logic level);
    int n;
    n = 0;
    while (full_r !== level && n < TMO) begin
      @(negedge clk);
      n++;
    end
    if (full_r !== level) begin
      report_timeout(level ? "pool full flag never rose" : "pool full flag never fell");
    end
  endtask

  initial begin
    llq_pkg::ctxt_t ctxt;
    logic           push;
    int             cnt;
    void'($urandom(30353));
    rst      = 1'b1;
    cmd_pass = 1'b0;
    cmd_push = 1'b0;
    cmd_data = '0;
    cmd_ctxt = '0;
    drv_used = 0;
    ctxt     = '0;
    for (int i = 0; i < NCTXT; i++) begin
      drv_cnt[i] = 0;
    end
    @(negedge clk);
    check_bit("accept during reset", 1'b0, cmd_accept);
    repeat (3) @(negedge clk);  // Four cycles of reset
    rst = 1'b0;
    @(negedge clk);
    check_empty("empty after reset", '1, empty_r);
    check_bit("full after reset", 1'b0, full_r);
    check_bit("lookup strobe after reset", 1'b0, lkup_pass_r);
    check_bit("accept after reset", 1'b1, cmd_accept);

    issue_cmd(1'b0, 3, '0);     // Empty fault
    for (int i = 0; i < 3; i++) begin
      issue_cmd(1'b1, 5, $urandom);
    end
    for (int i = 0; i < 4; i++) begin
      issue_cmd(1'b0, 5, '0);   // Back-to-back pops stall and the last one faults
    end

    // Random interleaving that keeps the context a third of the time
    repeat (300) begin
      if ($urandom_range(2) != 0) begin
        ctxt = llq_pkg::ctxt_t'($urandom_range(NCTXT - 1));
      end
      push = ($urandom_range(1) == 1) && (drv_used < NLINKS - 2);
      issue_cmd(push, ctxt, $urandom);
      if ($urandom_range(3) == 0) begin
        @(negedge clk);         // Idle gap
      end
    end

    // Drain every context so the pool starts empty
    wait_idle();
    for (int i = 0; i < NCTXT; i++) begin
      cnt = slots[i].size();
      repeat (cnt) issue_cmd(1'b0, llq_pkg::ctxt_t'(i), '0);
    end
    wait_idle();
    check_bit("full after drain", 1'b0, full_r);

    // Fill the pool
    repeat (NLINKS) issue_cmd(1'b1, llq_pkg::ctxt_t'($urandom_range(NCTXT - 1)), $urandom);
    wait_idle();
    wait_full(1'b1);
    cmd_pass = 1'b1;
    cmd_push = 1'b1;
    repeat (10) begin
      #1;
      check_bit("push accepted while full", 1'b0, cmd_accept);
      @(negedge clk);
    end
    cmd_pass = 1'b0;
    ctxt = '0;
    while (drv_cnt[ctxt] == 0) begin
      ctxt++;                   // First context holding an entry
    end
    issue_cmd(1'b0, ctxt, '0);  // Pop still accepted
    wait_full(1'b0);
    issue_cmd(1'b1, llq_pkg::ctxt_t'($urandom_range(NCTXT - 1)), $urandom);
    wait_idle();
    repeat (2) @(negedge clk);

    $display("Simulation passed");
    $finish;
  end

endmodule

//--- llq_top.f
+incdir+design
design/llq_pkg.sv
design/llq_op_if.sv
design/llq_result_if.sv
design/llq_cmd_stage.sv
design/llq_free_pool.sv
design/llq_link_ram.sv
design/llq_queue_engine.sv
design/llq_lookup_out.sv
design/llq_top.sv
bench/llq_tb.sv
